/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mcu_link_tb
FILELIST = mcu_link.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Result: FAILED
SIM      = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cclk_monitor.sv */
module cclk_monitor (
    input  logic clk_serial,
    input  logic arst_n,
    input  logic cclk,    // mcu drives this high once fpga config is done
    output logic ready
);

    mcu_link_pkg::cclk_count_t stable_cnt;  // consecutive high samples
    logic                      at_limit;

    // stop at the threshold so the counter never wraps back to zero
    assign at_limit = (stable_cnt == mcu_link_pkg::CCLK_READY_CNT);

    always_ff @(posedge clk_serial or negedge arst_n) begin
        if (!arst_n) begin
            stable_cnt <= '0;
        end else if (!cclk) begin
            stable_cnt <= '0;  // any low sample restarts the wait
        end else if (!at_limit) begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // while the mcu is still loading the fpga it toggles cclk and owns the line,
    // so nothing goes out until cclk has held high for the full window
    assign ready = at_limit;

endmodule

/* config_sync.sv */
module config_sync (
    input  logic                         clk_serial,
    input  logic                         arst_n,
    input  mcu_link_pkg::config_byte_t   tx_data_4x,      // from the 4x domain
    input  logic                         tx_new_data_4x,  // level, high while byte is new
    output mcu_link_pkg::config_update_t update
);

    // two-flop synchronizer, byte side has no reset
    mcu_link_pkg::config_byte_t data_meta;
    mcu_link_pkg::config_byte_t data_sync;
    mcu_link_pkg::config_byte_t data_q;     // byte presented with the strobe

    // two-flop synchronizer on the new-data level
    logic new_meta;
    logic new_sync;
    logic new_prev;   // last synced level, for edge detect
    logic strobe_q;   // registered rising edge

    always_ff @(posedge clk_serial) begin
        data_meta <= tx_data_4x;
        data_sync <= data_meta;
    end

    always_ff @(posedge clk_serial or negedge arst_n) begin
        if (!arst_n) begin
            new_meta <= 1'b0;
            new_sync <= 1'b0;
            new_prev <= 1'b0;
            strobe_q <= 1'b0;
        end else begin
            new_meta <= tx_new_data_4x;
            new_sync <= new_meta;
            new_prev <= new_sync;
            strobe_q <= new_sync & ~new_prev;  // one pulse per low to high change
        end
    end

    // byte is stable around the edge, so sample it alongside the strobe
    always_ff @(posedge clk_serial) begin
        data_q <= data_sync;
    end

    assign update.data   = data_q;
    assign update.strobe = strobe_q;

endmodule

/* mcu_link.f */
mcu_link_pkg.sv
config_sync.sv
cclk_monitor.sv
tx_byte_queue.sv
uart_tx.sv
mcu_link_top.sv
mcu_link_checker.sv
mcu_link_tb.sv

/* mcu_link_checker.sv */
module mcu_link_checker (
    input  logic                      clk_serial,
    input  logic                      arst_n,
    input  logic                      tx,
    input  mcu_link_pkg::uart_state_t state,      // transmitter state
    input  logic                      take,
    input  logic                      ready,
    input  logic                      not_empty,
    input  mcu_link_pkg::queue_ptr_t  wr_ptr,
    input  mcu_link_pkg::queue_ptr_t  rd_ptr
);

    mcu_link_pkg::queue_ptr_t fill;  // entries held, modulo pointer width

    assign fill = wr_ptr - rd_ptr;

    // the line is only driven low inside a frame
    idle_line_high: assert property (@(posedge clk_serial) disable iff (!arst_n)
        (state == mcu_link_pkg::UART_IDLE) |-> tx)
        else $error("tx low while the transmitter is idle");

    // a frame only starts from idle on a take, with the mcu ready and a byte pending
    take_gated: assert property (@(posedge clk_serial) disable iff (!arst_n)
        ((state == mcu_link_pkg::UART_START) && ($past(state) == mcu_link_pkg::UART_IDLE))
        |-> ($past(take) && $past(ready) && $past(not_empty)))
        else $error("frame started without a take from a ready mcu and a pending byte");

    fill_bounded: assert property (@(posedge clk_serial) disable iff (!arst_n)
        fill <= mcu_link_pkg::queue_ptr_t'(mcu_link_pkg::QUEUE_DEPTH))
        else $error("queue pointers are further apart than the depth");

endmodule

bind mcu_link_top mcu_link_checker u_checker (
    .clk_serial (clk_serial),
    .arst_n     (arst_n),
    .tx         (tx),
    .state      (u_uart.state),
    .take       (take),
    .ready      (ready),
    .not_empty  (not_empty),
    .wr_ptr     (u_queue.wr_ptr),
    .rd_ptr     (u_queue.rd_ptr)
);

/* mcu_link_pkg.sv */
package mcu_link_pkg;

    // serial timing
    localparam int CLKS_PER_BIT       = 16;  // clk_serial cycles per uart bit
    localparam int CCLK_STABLE_CYCLES = 64;  // cclk high this long means mcu is done

    // queue sizing
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_IDX_W = $clog2(QUEUE_DEPTH);  // address bits into the store

    // widths that carry a meaning
    typedef logic [7:0]             config_byte_t;  // chip config as reported by the core
    typedef logic [3:0]             baud_count_t;   // position inside one serial bit
    typedef logic [2:0]             bit_index_t;    // which data bit is on the line
    typedef logic [QUEUE_IDX_W:0]   queue_ptr_t;    // extra msb tells full from empty
    typedef logic [6:0]             cclk_count_t;   // debounce count, saturates

    // derived compare values, typed to match their counters
    localparam baud_count_t BAUD_LAST      = baud_count_t'(CLKS_PER_BIT - 1);
    localparam bit_index_t  LAST_DATA_BIT  = bit_index_t'($bits(config_byte_t) - 1);
    localparam cclk_count_t CCLK_READY_CNT = cclk_count_t'(CCLK_STABLE_CYCLES);

    // transmitter states
    typedef enum logic [1:0] {
        UART_IDLE,   // line high, waiting for a byte and a ready mcu
        UART_START,  // start bit, line low
        UART_DATA,   // eight data bits, lsb first
        UART_STOP    // stop bit, line high
    } uart_state_t;

    // byte that just crossed into clk_serial, strobe is one cycle wide
    typedef struct packed {
        config_byte_t data;
        logic         strobe;
    } config_update_t;

endpackage

/* mcu_link_tb.sv */
module mcu_link_tb;

    logic                       clk_serial;
    logic                       arst_n;
    mcu_link_pkg::config_byte_t tx_data_4x;
    logic                       tx_new_data_4x;
    logic                       cclk;
    logic                       tx;
    logic                       mcu_ready;
    logic                       overflow;

    integer seed;  // $random state

    // reference model of the link, advanced on every rising edge
    mcu_link_pkg::config_byte_t exp_q [$];       // accepted by the queue, not yet decoded
    mcu_link_pkg::config_byte_t push_data;       // byte on its way through the sync
    int                         pending    = 0;  // bytes held in the dut queue
    int                         frame_left = 0;  // cycles until the transmitter idles
    int                         push_delay = 0;  // edges until the byte lands in the queue
    int                         cclk_cnt   = 0;  // consecutive high cclk samples
    logic                       level_seen     = 1'b0;
    logic                       model_ready    = 1'b0;
    logic                       model_overflow = 1'b0;
    logic                       model_take;
    logic                       model_push;
    logic                       sends_done = 1'b1;  // no more bytes coming from the sender

    mcu_link_top UUT (
        .clk_serial     (clk_serial),
        .arst_n         (arst_n),
        .tx_data_4x     (tx_data_4x),
        .tx_new_data_4x (tx_new_data_4x),
        .cclk           (cclk),
        .tx             (tx),
        .mcu_ready      (mcu_ready),
        .overflow       (overflow)
    );

    initial begin
        clk_serial = 1'b0;
        forever #5 clk_serial = ~clk_serial;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input mcu_link_pkg::config_byte_t actual,
                              input mcu_link_pkg::config_byte_t expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    // byte one edge ahead of the level, as the sync needs it
    task automatic present_byte(input mcu_link_pkg::config_byte_t b);
        @(posedge clk_serial);
        tx_data_4x <= b;
        @(posedge clk_serial);
        tx_new_data_4x <= 1'b1;
    endtask

    // two high samples, then low long enough for the next rising edge
    task automatic release_level();
        repeat (2) @(posedge clk_serial);
        tx_new_data_4x <= 1'b0;
        repeat (3) @(posedge clk_serial);  // data held past the fall
    endtask

    task automatic send_byte(input mcu_link_pkg::config_byte_t b);
        present_byte(b);
        release_level();
    endtask

    task automatic hold_line_high(input int cycles);
        repeat (cycles) begin
            @(negedge clk_serial);
            check_line("tx", tx, 1'b1);
        end
    endtask

    task automatic wait_for_ready(input int limit);
        int waited;
        waited = 0;
        while (mcu_ready !== 1'b1) begin
            if (waited == limit) begin
                $display("timeout: mcu_ready did not rise within %0d cycles", limit);
                abort_run();
            end
            @(negedge clk_serial);
            waited++;
        end
    endtask

    // returns with found low once the sender is done and nothing is left to decode
    task automatic wait_start_bit(output logic found);
        int waited;
        waited = 0;
        found  = 1'b0;
        while (!found && !(sends_done && exp_q.size() == 0)) begin
            if (waited == 2000) begin
                $display("timeout: no start bit on tx within 2000 cycles");
                abort_run();
            end
            @(negedge clk_serial);
            waited++;
            if (tx === 1'b0) begin
                found = 1'b1;  // half a cycle into the start bit
            end
        end
    endtask

    // entered half a cycle into the start bit, samples each bit near its middle
    task automatic decode_frame(output mcu_link_pkg::config_byte_t b);
        int i;
        b = '0;
        repeat (mcu_link_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clk_serial);
        check_line("tx start bit", tx, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (mcu_link_pkg::CLKS_PER_BIT) @(negedge clk_serial);
            b[i] = tx;  // lsb first
        end
        repeat (mcu_link_pkg::CLKS_PER_BIT) @(negedge clk_serial);
        check_line("tx stop bit", tx, 1'b1);
    endtask

    task automatic next_expected(output mcu_link_pkg::config_byte_t e);
        if (exp_q.size() == 0) begin
            $display("a frame appeared on tx while the model held no pending byte");
            abort_run();
        end
        e = exp_q.pop_front();
    endtask

    task automatic receive_and_compare();
        logic                       found;
        mcu_link_pkg::config_byte_t got;
        mcu_link_pkg::config_byte_t want;
        wait_start_bit(found);
        if (found) begin
            decode_frame(got);
            next_expected(want);
            check_byte("tx data", got, want);
        end
    endtask

    task automatic drain_frames();
        while (!(sends_done && exp_q.size() == 0)) begin
            receive_and_compare();
        end
    endtask

    always @(posedge clk_serial or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();
            pending        = 0;
            frame_left     = 0;
            push_delay     = 0;
            cclk_cnt       = 0;
            level_seen     = 1'b0;
            model_ready    = 1'b0;
            model_overflow = 1'b0;
        end else begin
            // take and push are decided on the state before this edge
            model_take = (frame_left == 0) && model_ready && (pending > 0);
            model_push = (push_delay == 1);
            if (push_delay != 0) begin
                push_delay = push_delay - 1;
            end
            if (tx_new_data_4x && !level_seen) begin
                push_delay = 3;  // lands in the queue three edges later
                push_data  = tx_data_4x;
            end
            level_seen = tx_new_data_4x;
            if (model_push) begin
                if (pending == mcu_link_pkg::QUEUE_DEPTH) begin
                    model_overflow = 1'b1;  // full, byte lost
                end else begin
                    exp_q.push_back(push_data);
                    pending = pending + 1;
                end
            end
            if (model_take) begin
                pending    = pending - 1;
                frame_left = 10 * mcu_link_pkg::CLKS_PER_BIT;  // start, 8 data, stop
            end else if (frame_left != 0) begin
                frame_left = frame_left - 1;
            end
            if (!cclk) begin
                cclk_cnt = 0;
            end else if (cclk_cnt < mcu_link_pkg::CCLK_STABLE_CYCLES) begin
                cclk_cnt = cclk_cnt + 1;
            end
            model_ready = (cclk_cnt == mcu_link_pkg::CCLK_STABLE_CYCLES);
        end
    end

    // flags follow the model on every cycle
    always @(negedge clk_serial) begin
        if (arst_n) begin
            check_flag("mcu_ready", mcu_ready, model_ready);
            check_flag("overflow", overflow, model_overflow);
        end
    end

    initial begin
        mcu_link_pkg::config_byte_t one;
        mcu_link_pkg::config_byte_t got;
        mcu_link_pkg::config_byte_t want;
        mcu_link_pkg::config_byte_t sent [6];
        logic                       found;
        integer                     r;
        int                         i;
        int                         k;
        int                         gap;

        seed           = 32'h8647_399c;
        arst_n         = 1'b0;
        cclk           = 1'b0;
        tx_data_4x     = '0;
        tx_new_data_4x = 1'b0;
        repeat (10) @(posedge clk_serial);
        arst_n <= 1'b1;

        // mcu still configuring, bytes wait in the queue
        for (i = 0; i < 3; i++) begin
            send_byte(mcu_link_pkg::config_byte_t'($random(seed)));
        end
        hold_line_high(300);
        check_flag("mcu_ready", mcu_ready, 1'b0);

        // readiness, a short high run and one low sample restart the count
        @(posedge clk_serial);
        cclk <= 1'b1;
        repeat (30) @(posedge clk_serial);
        cclk <= 1'b0;
        @(posedge clk_serial);
        cclk <= 1'b1;
        repeat (mcu_link_pkg::CCLK_STABLE_CYCLES) begin
            @(negedge clk_serial);
            check_flag("mcu_ready", mcu_ready, 1'b0);
        end
        @(negedge clk_serial);
        check_flag("mcu_ready", mcu_ready, 1'b1);
        sends_done = 1'b1;
        drain_frames();  // the three held bytes
        @(posedge clk_serial);
        cclk <= 1'b0;
        @(negedge clk_serial);
        check_flag("mcu_ready", mcu_ready, 1'b1);
        @(negedge clk_serial);
        check_flag("mcu_ready", mcu_ready, 1'b0);  // first low sample clears it
        @(posedge clk_serial);
        cclk <= 1'b1;
        wait_for_ready(200);

        // single frame, start bit five edges after the level is driven
        one        = mcu_link_pkg::config_byte_t'($random(seed));
        sends_done = 1'b0;
        present_byte(one);
        fork
            release_level();
            begin
                for (k = 0; k < 6; k++) begin
                    @(negedge clk_serial);
                    check_line("tx", tx, (k == 5) ? 1'b0 : 1'b1);
                end
            end
            begin
                wait_start_bit(found);
                decode_frame(got);
                next_expected(want);
                check_byte("tx data", got, one);
            end
        join
        sends_done = 1'b1;

        // ordering under load, gaps mostly longer than a frame
        sends_done = 1'b0;
        fork
            begin
                for (i = 0; i < 20; i++) begin
                    send_byte(mcu_link_pkg::config_byte_t'($random(seed)));
                    r = $random(seed);
                    if (r[1:0] == 2'b00) begin
                        gap = $unsigned($random(seed)) % 41;  // burst
                    end else begin
                        gap = 160 + $unsigned($random(seed)) % 200;
                    end
                    repeat (gap) @(posedge clk_serial);
                end
                sends_done = 1'b1;
            end
            drain_frames();
        join

        // overflow, six bytes into four entries while not ready
        @(posedge clk_serial);
        cclk <= 1'b0;
        for (i = 0; i < 6; i++) begin
            sent[i] = mcu_link_pkg::config_byte_t'($random(seed));
            send_byte(sent[i]);
        end
        hold_line_high(200);
        check_flag("overflow", overflow, 1'b1);
        @(posedge clk_serial);
        cclk <= 1'b1;
        sends_done = 1'b0;
        for (k = 0; k < 4; k++) begin
            wait_start_bit(found);
            decode_frame(got);
            next_expected(want);
            check_byte("tx data", got, sent[k]);
        end
        if (exp_q.size() != 0) begin
            $display("model still expects %0d bytes after the overflow test", exp_q.size());
            abort_run();
        end
        sends_done = 1'b1;
        hold_line_high(300);  // dropped bytes never show up
        check_flag("overflow", overflow, 1'b1);

        // cclk drops during a frame, the frame still completes
        wait_for_ready(200);
        sends_done = 1'b0;
        fork
            begin
                for (i = 0; i < 3; i++) begin
                    send_byte(mcu_link_pkg::config_byte_t'($random(seed)));
                end
            end
            begin
                wait_start_bit(found);
                fork
                    decode_frame(got);
                    begin
                        repeat (60) @(posedge clk_serial);
                        cclk <= 1'b0;
                    end
                join
                next_expected(want);
                check_byte("tx data", got, want);
            end
        join
        hold_line_high(400);  // two bytes wait for the mcu
        @(posedge clk_serial);
        cclk <= 1'b1;
        sends_done = 1'b1;
        drain_frames();
        hold_line_high(50);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* mcu_link_top.sv */
module mcu_link_top (
    input  logic                       clk_serial,
    input  logic                       arst_n,
    input  mcu_link_pkg::config_byte_t tx_data_4x,      // config byte from the video core
    input  logic                       tx_new_data_4x,  // new-data level
    input  logic                       cclk,            // from the board mcu
    output logic                       tx,              // serial line to the mcu
    output logic                       mcu_ready,
    output logic                       overflow         // a config byte was dropped
);

    mcu_link_pkg::config_update_t update;  // synced byte plus one-cycle strobe
    mcu_link_pkg::config_byte_t   head;
    logic                         not_empty;
    logic                         take;
    logic                         ready;

    // 4x domain into clk_serial
    config_sync u_sync (
        .clk_serial     (clk_serial),
        .arst_n         (arst_n),
        .tx_data_4x     (tx_data_4x),
        .tx_new_data_4x (tx_new_data_4x),
        .update         (update)
    );

    // holds the line off until the mcu has finished loading us
    cclk_monitor u_cclk (
        .clk_serial (clk_serial),
        .arst_n     (arst_n),
        .cclk       (cclk),
        .ready      (ready)
    );

    tx_byte_queue u_queue (
        .clk_serial (clk_serial),
        .arst_n     (arst_n),
        .update     (update),
        .take       (take),
        .head       (head),
        .not_empty  (not_empty),
        .overflow   (overflow)
    );

    uart_tx u_uart (
        .clk_serial (clk_serial),
        .arst_n     (arst_n),
        .ready      (ready),
        .head       (head),
        .not_empty  (not_empty),
        .take       (take),
        .tx         (tx)
    );

    assign mcu_ready = ready;

endmodule

/* tx_byte_queue.sv */
module tx_byte_queue (
    input  logic                         clk_serial,
    input  logic                         arst_n,
    input  mcu_link_pkg::config_update_t update,     // push on strobe
    input  logic                         take,       // pop, one cycle from uart
    output mcu_link_pkg::config_byte_t   head,       // oldest pending byte
    output logic                         not_empty,
    output logic                         overflow    // sticky, cleared by reset only
);

    localparam int IW = mcu_link_pkg::QUEUE_IDX_W;

    mcu_link_pkg::config_byte_t mem [mcu_link_pkg::QUEUE_DEPTH];  // payload, no reset
    mcu_link_pkg::queue_ptr_t   wr_ptr;
    mcu_link_pkg::queue_ptr_t   rd_ptr;

    logic full;
    logic empty;
    logic push;
    logic pop;

    // same index with msb flipped means the writer lapped the reader
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[IW] != rd_ptr[IW]) && (wr_ptr[IW-1:0] == rd_ptr[IW-1:0]);

    assign push = update.strobe & ~full;  // byte is lost when full
    assign pop  = take & ~empty;

    // storage write
    always_ff @(posedge clk_serial) begin
        if (push) begin
            mem[wr_ptr[IW-1:0]] <= update.data;
        end
    end

    // pointers, push and pop may both happen in one cycle
    always_ff @(posedge clk_serial or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // drop flag
    always_ff @(posedge clk_serial or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (update.strobe && full) begin
            overflow <= 1'b1;  // stays up so the loss is never missed
        end
    end

    assign head      = mem[rd_ptr[IW-1:0]];
    assign not_empty = ~empty;

endmodule

/* uart_tx.sv */
module uart_tx (
    input  logic                       clk_serial,
    input  logic                       arst_n,
    input  logic                       ready,      // mcu done configuring
    input  mcu_link_pkg::config_byte_t head,       // next byte from the queue
    input  logic                       not_empty,
    output logic                       take,       // pop strobe back to the queue
    output logic                       tx          // serial line, idles high
);

    mcu_link_pkg::uart_state_t  state;
    mcu_link_pkg::baud_count_t  baud_cnt;   // cycles spent in the current bit
    mcu_link_pkg::bit_index_t   bit_idx;    // data bit now on the line
    mcu_link_pkg::config_byte_t shift_q;    // byte being sent, lsb goes out next

    logic bit_done;   // last cycle of the current bit
    logic shifting;   // start or data bit ending, advance the shifter

    // only place a frame can begin, once begun it runs to the stop bit
    assign take     = (state == mcu_link_pkg::UART_IDLE) && ready && not_empty;
    assign bit_done = (baud_cnt == mcu_link_pkg::BAUD_LAST);
    assign shifting = bit_done && ((state == mcu_link_pkg::UART_START) ||
                                   (state == mcu_link_pkg::UART_DATA));

    // shift register, loaded on take
    always_ff @(posedge clk_serial) begin
        if (take) begin
            shift_q <= head;
        end else if (shifting) begin
            shift_q <= shift_q >> 1;
        end
    end

    // control and line, tx is registered so it never glitches
    always_ff @(posedge clk_serial or negedge arst_n) begin
        if (!arst_n) begin
            state    <= mcu_link_pkg::UART_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
        end else begin
            // baud counter runs in every bit state
            if (state == mcu_link_pkg::UART_IDLE || bit_done) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end

            case (state)
                mcu_link_pkg::UART_IDLE: begin
                    tx <= 1'b1;
                    if (take) begin
                        state <= mcu_link_pkg::UART_START;
                        tx    <= 1'b0;  // start bit
                    end
                end
                mcu_link_pkg::UART_START: begin
                    if (bit_done) begin
                        state   <= mcu_link_pkg::UART_DATA;
                        bit_idx <= '0;
                        tx      <= shift_q[0];  // bit 0 first
                    end
                end
                mcu_link_pkg::UART_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == mcu_link_pkg::LAST_DATA_BIT) begin
                            state <= mcu_link_pkg::UART_STOP;
                            tx    <= 1'b1;  // stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_q[0];  // already shifted down
                        end
                    end
                end
                mcu_link_pkg::UART_STOP: begin
                    if (bit_done) begin
                        state <= mcu_link_pkg::UART_IDLE;  // line stays high
                    end
                end
                default: begin
                    state <= mcu_link_pkg::UART_IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

endmodule
